// File: source/sram_pkg.sv
package sram_pkg;

  // Bus and chip widths, one 16-bit word per address
  localparam int sram_addr_width = 20;
  localparam int sram_data_width = 16;
  localparam int sram_strb_width = (sram_data_width + 7) / 8;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Cycles with we_n low during a write
  localparam int write_pulse_cycles = 2;

  // Wait cycles with oe_n low before read data is sampled
  localparam int read_wait_cycles = 2;

  // Shared cycle counter, sized for the longer phase
  localparam int sram_cnt_max =
    (write_pulse_cycles > read_wait_cycles) ? write_pulse_cycles : read_wait_cycles;
  localparam int sram_cnt_width = $clog2(sram_cnt_max + 1);

endpackage

// File: source/sram_controller.sv
`timescale 1ns/1ps

module sram_controller (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,

  // Request side, from the bus slave
  input  logic                                 req,
  input  logic                                 write,
  input  logic [sram_pkg::sram_addr_width-1:0] addr,
  input  logic [sram_pkg::sram_data_width-1:0] wdata,
  output logic                                 ready,
  output logic [sram_pkg::sram_data_width-1:0] rdata,

  // Chip pins
  output logic [sram_pkg::sram_addr_width-1:0] io_addr,
  inout  wire  [sram_pkg::sram_data_width-1:0] io_data,
  output logic                                 io_we_n,
  output logic                                 io_oe_n,
  output logic                                 io_ce_n
);

  import sram_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_setup,
    st_write_pulse,
    st_write_end,
    st_read_wait,
    st_read_end
  } state_t;

  state_t state;
  state_t state_next;

  logic [sram_cnt_width-1:0]  cnt;
  logic                       write_q;
  logic [sram_addr_width-1:0] addr_q;
  logic [sram_data_width-1:0] wdata_q;
  logic [sram_data_width-1:0] rdata_q;
  logic                       data_drive;
  logic                       sample;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (req) begin
          state_next = st_setup;
        end
      end
      // Address and ce_n settle for one cycle
      st_setup: begin
        state_next = write_q ? st_write_pulse : st_read_wait;
      end
      st_write_pulse: begin
        if (cnt == sram_cnt_width'(write_pulse_cycles - 1)) begin
          state_next = st_write_end;
        end
      end
      // we_n back high, data still held for the hold time
      st_write_end: begin
        state_next = st_idle;
      end
      st_read_wait: begin
        if (cnt == sram_cnt_width'(read_wait_cycles)) begin
          state_next = st_read_end;
        end
      end
      st_read_end: begin
        state_next = st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Phase counter restarts on every state change
  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      cnt <= '0;
    end else if (state != state_next) begin
      cnt <= '0;
    end else if (state == st_write_pulse || state == st_read_wait) begin
      cnt <= cnt + 1'b1;
    end
  end

  // Request is captured while idle
  always_ff @(posedge axi_clk) begin
    if (state == st_idle && req) begin
      write_q <= write;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign sample = (state == st_read_wait) && (state_next == st_read_end);

  always_ff @(posedge axi_clk) begin
    if (sample) begin
      rdata_q <= io_data;
    end
  end

  assign data_drive = (state == st_write_pulse) || (state == st_write_end);

  assign io_addr = addr_q;
  assign io_data = data_drive ? wdata_q : {sram_data_width{1'bz}};
  assign io_ce_n = (state == st_idle) || (state == st_read_end);
  assign io_we_n = (state != st_write_pulse);
  assign io_oe_n = !(((state == st_setup) && !write_q) || (state == st_read_wait));

  // One-cycle completion pulse for both directions
  assign ready = (state == st_write_end) || (state == st_read_end);
  assign rdata = rdata_q;

endmodule

// File: source/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,

  // Write address channel
  input  logic [sram_pkg::sram_addr_width-1:0] axi_awaddr,
  input  logic                                 axi_awvalid,
  output logic                                 axi_awready,

  // Write data channel
  input  logic [sram_pkg::sram_data_width-1:0] axi_wdata,
  input  logic [sram_pkg::sram_strb_width-1:0] axi_wstrb,
  input  logic                                 axi_wvalid,
  output logic                                 axi_wready,

  // Write response channel
  output logic [1:0]                           axi_bresp,
  output logic                                 axi_bvalid,
  input  logic                                 axi_bready,

  // Read address channel
  input  logic [sram_pkg::sram_addr_width-1:0] axi_araddr,
  input  logic                                 axi_arvalid,
  output logic                                 axi_arready,

  // Read data channel
  output logic [sram_pkg::sram_data_width-1:0] axi_rdata,
  output logic [1:0]                           axi_rresp,
  output logic                                 axi_rvalid,
  input  logic                                 axi_rready,

  // Link to the SRAM controller
  output logic                                 sram_req,
  output logic                                 sram_write,
  output logic [sram_pkg::sram_addr_width-1:0] sram_addr,
  output logic [sram_pkg::sram_data_width-1:0] sram_wdata,
  input  logic                                 sram_ready,
  input  logic [sram_pkg::sram_data_width-1:0] sram_rdata
);

  import sram_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_write_wait,
    st_write_resp,
    st_read_wait,
    st_read_resp
  } state_t;

  state_t state;
  state_t state_next;

  logic                       write_pending;
  logic                       write_accept;
  logic                       read_accept;
  logic                       strb_full;
  logic                       req_q;
  logic                       write_q;
  logic [sram_addr_width-1:0] addr_q;
  logic [sram_data_width-1:0] wdata_q;
  logic [1:0]                 bresp_q;
  logic [sram_data_width-1:0] rdata_q;

  // Pins for the upper and lower byte are tied, so only full words go out
  assign strb_full = &axi_wstrb;

  // Write needs address and data together, and beats a pending read
  assign write_pending = axi_awvalid && axi_wvalid;
  assign write_accept  = (state == st_idle) && write_pending;
  assign read_accept   = (state == st_idle) && axi_arvalid && !write_pending;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (write_accept) begin
          state_next = strb_full ? st_write_wait : st_write_resp;
        end else if (read_accept) begin
          state_next = st_read_wait;
        end
      end
      st_write_wait: begin
        if (sram_ready) begin
          state_next = st_write_resp;
        end
      end
      // Held here until the master takes the response
      st_write_resp: begin
        if (axi_bready) begin
          state_next = st_idle;
        end
      end
      st_read_wait: begin
        if (sram_ready) begin
          state_next = st_read_resp;
        end
      end
      st_read_resp: begin
        if (axi_rready) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Request pulse in the cycle after the address handshake
  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      req_q <= 1'b0;
    end else begin
      req_q <= (write_accept && strb_full) || read_accept;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (write_accept) begin
      write_q <= 1'b1;
      addr_q  <= axi_awaddr;
      wdata_q <= axi_wdata;
      bresp_q <= strb_full ? resp_okay : resp_slverr;
    end else if (read_accept) begin
      write_q <= 1'b0;
      addr_q  <= axi_araddr;
    end
  end

  // Read word kept stable while rvalid waits for rready
  always_ff @(posedge axi_clk) begin
    if (state == st_read_wait && sram_ready) begin
      rdata_q <= sram_rdata;
    end
  end

  assign axi_awready = write_accept;
  assign axi_wready  = write_accept;
  assign axi_arready = read_accept;

  assign axi_bvalid = (state == st_write_resp);
  assign axi_bresp  = bresp_q;

  assign axi_rvalid = (state == st_read_resp);
  assign axi_rdata  = rdata_q;
  assign axi_rresp  = resp_okay;

  assign sram_req   = req_q;
  assign sram_write = write_q;
  assign sram_addr  = addr_q;
  assign sram_wdata = wdata_q;

endmodule

// File: source/sram_subsystem_top.sv
`timescale 1ns/1ps

module sram_subsystem_top (
  input  logic                                 axi_clk,
  input  logic                                 axi_resetn,

  input  logic [sram_pkg::sram_addr_width-1:0] axi_awaddr,
  input  logic                                 axi_awvalid,
  output logic                                 axi_awready,

  input  logic [sram_pkg::sram_data_width-1:0] axi_wdata,
  input  logic [sram_pkg::sram_strb_width-1:0] axi_wstrb,
  input  logic                                 axi_wvalid,
  output logic                                 axi_wready,

  output logic [1:0]                           axi_bresp,
  output logic                                 axi_bvalid,
  input  logic                                 axi_bready,

  input  logic [sram_pkg::sram_addr_width-1:0] axi_araddr,
  input  logic                                 axi_arvalid,
  output logic                                 axi_arready,

  output logic [sram_pkg::sram_data_width-1:0] axi_rdata,
  output logic [1:0]                           axi_rresp,
  output logic                                 axi_rvalid,
  input  logic                                 axi_rready,

  // External asynchronous SRAM
  output logic [sram_pkg::sram_addr_width-1:0] sram_io_addr,
  inout  wire  [sram_pkg::sram_data_width-1:0] sram_io_data,
  output logic                                 sram_io_we_n,
  output logic                                 sram_io_oe_n,
  output logic                                 sram_io_ce_n
);

  import sram_pkg::*;

  // Request and ready link between the two blocks
  logic                       sram_req;
  logic                       sram_write;
  logic [sram_addr_width-1:0] sram_addr;
  logic [sram_data_width-1:0] sram_wdata;
  logic                       sram_ready;
  logic [sram_data_width-1:0] sram_rdata;

  axi_sram_slave u_slave (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .axi_awaddr  (axi_awaddr),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wdata   (axi_wdata),
    .axi_wstrb   (axi_wstrb),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_bresp   (axi_bresp),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready),
    .axi_araddr  (axi_araddr),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_rdata   (axi_rdata),
    .axi_rresp   (axi_rresp),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready),
    .sram_req    (sram_req),
    .sram_write  (sram_write),
    .sram_addr   (sram_addr),
    .sram_wdata  (sram_wdata),
    .sram_ready  (sram_ready),
    .sram_rdata  (sram_rdata)
  );

  sram_controller u_ctrl (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .req        (sram_req),
    .write      (sram_write),
    .addr       (sram_addr),
    .wdata      (sram_wdata),
    .ready      (sram_ready),
    .rdata      (sram_rdata),
    .io_addr    (sram_io_addr),
    .io_data    (sram_io_data),
    .io_we_n    (sram_io_we_n),
    .io_oe_n    (sram_io_oe_n),
    .io_ce_n    (sram_io_ce_n)
  );

endmodule

// File: bench/async_sram_model.sv
`timescale 1ns/1ps

module async_sram_model (
  input  logic [sram_pkg::sram_addr_width-1:0] addr,
  inout  wire  [sram_pkg::sram_data_width-1:0] data,
  input  logic                                 we_n,
  input  logic                                 oe_n,
  input  logic                                 ce_n
);

  import sram_pkg::*;

  logic [sram_data_width-1:0] mem [0:(1 << sram_addr_width)-1];

  // Power-up contents, every address bit takes part
  function automatic logic [sram_data_width-1:0] initial_word(
    logic [sram_addr_width-1:0] a
  );
    return {a[7:0], a[15:8]} ^ {12'h000, a[19:16]} ^ 16'h3c5a;
  endfunction

  initial begin
    for (int i = 0; i < (1 << sram_addr_width); i++) begin
      mem[i] = initial_word(sram_addr_width'(i));
    end
  end

  // Data latched at the rising edge of we_n
  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] = data;
    end
  end

  // Drives the bus only while selected for a read
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : {sram_data_width{1'bz}};

endmodule

// File: bench/tb_sram_subsystem.sv
`timescale 1ns/1ps

module tb_sram_subsystem;

  import sram_pkg::*;

  localparam int reset_cycles = 10;
  localparam int random_txns  = 200;
  // Directed tests add 22 transactions
  localparam int total_txns     = 22 + random_txns;
  localparam int timeout_cycles = total_txns * 40 + reset_cycles;
  localparam logic [sram_addr_width-1:0] window_base = 20'h5a3c0;

  logic                       axi_clk;
  logic                       axi_resetn;
  logic [sram_addr_width-1:0] axi_awaddr;
  logic                       axi_awvalid;
  logic                       axi_awready;
  logic [sram_data_width-1:0] axi_wdata;
  logic [sram_strb_width-1:0] axi_wstrb;
  logic                       axi_wvalid;
  logic                       axi_wready;
  logic [1:0]                 axi_bresp;
  logic                       axi_bvalid;
  logic                       axi_bready;
  logic [sram_addr_width-1:0] axi_araddr;
  logic                       axi_arvalid;
  logic                       axi_arready;
  logic [sram_data_width-1:0] axi_rdata;
  logic [1:0]                 axi_rresp;
  logic                       axi_rvalid;
  logic                       axi_rready;
  logic [sram_addr_width-1:0] sram_io_addr;
  wire  [sram_data_width-1:0] sram_io_data;
  logic                       sram_io_we_n;
  logic                       sram_io_oe_n;
  logic                       sram_io_ce_n;

  logic [31:0]                lfsr_state;
  logic [sram_data_width-1:0] shadow [logic [sram_addr_width-1:0]];
  logic [1:0]                 exp_bresp [$];
  string                      exp_bname [$];
  logic [sram_data_width-1:0] exp_rdata [$];
  string                      exp_rname [$];

  sram_subsystem_top dut (.*);

  async_sram_model u_sram (
    .addr (sram_io_addr),
    .data (sram_io_data),
    .we_n (sram_io_we_n),
    .oe_n (sram_io_oe_n),
    .ce_n (sram_io_ce_n)
  );

  initial begin
    axi_clk = 1'b0;
    forever #50 axi_clk = ~axi_clk;
  end

  initial begin
    repeat (timeout_cycles) @(posedge axi_clk);
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < n; i++) begin
      result     = {result[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
    end
    return result;
  endfunction

  function automatic logic [sram_data_width-1:0] power_up_word(logic [sram_addr_width-1:0] a);
    return {a[7:0], a[15:8]} ^ {12'h000, a[19:16]} ^ 16'h3c5a;
  endfunction

  // Partial strobes are refused since the byte pins are tied
  function automatic logic [1:0] expected_bresp(logic [sram_strb_width-1:0] strb);
    return (&strb) ? resp_okay : resp_slverr;
  endfunction

  function automatic logic [sram_data_width-1:0] expected_rdata(
    logic [sram_addr_width-1:0] addr
  );
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return power_up_word(addr);
  endfunction

  function automatic logic [31:0] resp_word(bit is_read);
    return is_read ? {14'd0, axi_rresp, axi_rdata} : 32'(axi_bresp);
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_idle_outputs(string name);
    check_value({name, " ce_n"}, 32'd1, 32'(sram_io_ce_n));
    check_value({name, " we_n"}, 32'd1, 32'(sram_io_we_n));
    check_value({name, " oe_n"}, 32'd1, 32'(sram_io_oe_n));
    check_value({name, " awready"}, 32'd0, 32'(axi_awready));
    check_value({name, " wready"}, 32'd0, 32'(axi_wready));
    check_value({name, " arready"}, 32'd0, 32'(axi_arready));
    check_value({name, " bvalid"}, 32'd0, 32'(axi_bvalid));
    check_value({name, " rvalid"}, 32'd0, 32'(axi_rvalid));
  endtask

  task automatic check_no_accept();
    check_value("awready while busy", 32'd0, 32'(axi_awready));
    check_value("arready while busy", 32'd0, 32'(axi_arready));
  endtask

  task automatic start_write(logic [sram_addr_width-1:0] addr,
                             logic [sram_data_width-1:0] data,
                             logic [sram_strb_width-1:0] strb, string name);
    axi_awaddr  = addr;
    axi_wdata   = data;
    axi_wstrb   = strb;
    axi_awvalid = 1'b1;
    axi_wvalid  = 1'b1;
    exp_bresp.push_back(expected_bresp(strb));
    exp_bname.push_back(name);
    if (expected_bresp(strb) == resp_okay) begin
      shadow[addr] = data;
    end
  endtask

  task automatic start_read(logic [sram_addr_width-1:0] addr, string name);
    axi_araddr  = addr;
    axi_arvalid = 1'b1;
    exp_rdata.push_back(expected_rdata(addr));
    exp_rname.push_back(name);
  endtask

  // Valids drop right after the address handshake
  task automatic wait_accept(bit is_read);
    do begin
      @(negedge axi_clk);
      check_value("wready with awready", 32'(axi_awready), 32'(axi_wready));
    end while (!(is_read ? axi_arready : axi_awready));
    @(posedge axi_clk);
    #5;
    if (is_read) begin
      axi_arvalid = 1'b0;
    end else begin
      axi_awvalid = 1'b0;
      axi_wvalid  = 1'b0;
    end
  endtask

  // Response must hold still while ready stays low
  task automatic take_resp(bit is_read, int stall);
    logic [31:0] held;
    do begin
      @(negedge axi_clk);
      check_no_accept();
    end while (!(is_read ? axi_rvalid : axi_bvalid));
    held = resp_word(is_read);
    repeat (stall) begin
      @(negedge axi_clk);
      check_value("valid under stall", 32'd1, 32'(is_read ? axi_rvalid : axi_bvalid));
      check_value("response under stall", held, resp_word(is_read));
      check_no_accept();
    end
    @(posedge axi_clk);
    #5;
    axi_bready = !is_read;
    axi_rready = is_read;
    @(posedge axi_clk);
    #5;
    axi_bready = 1'b0;
    axi_rready = 1'b0;
  endtask

  task automatic send_write(logic [sram_addr_width-1:0] addr,
                            logic [sram_data_width-1:0] data,
                            logic [sram_strb_width-1:0] strb, int stall, string name);
    start_write(addr, data, strb, name);
    wait_accept(1'b0);
    take_resp(1'b0, stall);
  endtask

  task automatic send_read(logic [sram_addr_width-1:0] addr, int stall, string name);
    start_read(addr, name);
    wait_accept(1'b1);
    take_resp(1'b1, stall);
  endtask

  // Compare each response at the negedge before its handshake edge
  always @(negedge axi_clk) begin : compare_writes
    string name;
    if (axi_resetn && axi_bvalid && axi_bready) begin
      if (exp_bresp.size() == 0) begin
        $display("A write response arrived with no write outstanding");
        $display("STATUS: FAIL");
        $fatal(1, "unexpected write response");
      end else begin
        name = exp_bname.pop_front();
        check_value({name, " bresp"}, 32'(exp_bresp.pop_front()), 32'(axi_bresp));
      end
    end
  end

  always @(negedge axi_clk) begin : compare_reads
    string name;
    if (axi_resetn && axi_rvalid && axi_rready) begin
      if (exp_rdata.size() == 0) begin
        $display("A read response arrived with no read outstanding");
        $display("STATUS: FAIL");
        $fatal(1, "unexpected read response");
      end else begin
        name = exp_rname.pop_front();
        check_value({name, " rresp"}, 32'(resp_okay), 32'(axi_rresp));
        check_value({name, " rdata"}, 32'(exp_rdata.pop_front()), 32'(axi_rdata));
      end
    end
  end

  task automatic readback_test();
    logic [sram_addr_width-1:0] addrs [6];
    logic [31:0]                bits;
    for (int i = 0; i < 6; i++) begin
      bits     = take_bits(16);
      addrs[i] = (i == 0) ? '0 : (i == 5) ? '1 : {4'(i), bits[15:0]};
      send_write(addrs[i], {4'(i), 12'ha6c}, 2'b11, 0, "readback write");
    end
    for (int i = 0; i < 6; i++) begin
      send_read(addrs[i], 0, "readback read");
    end
  endtask

  task automatic strobe_test();
    send_write(20'h00321, 16'h4d2e, 2'b11, 0, "strobe full");
    send_write(20'h00321, 16'h5a5a, 2'b01, 0, "strobe low byte");
    send_write(20'h00321, 16'ha5a5, 2'b10, 0, "strobe high byte");
    send_read(20'h00321, 0, "strobe readback");
  endtask

  task automatic backpressure_test();
    logic [31:0] bits;
    int          wstall;
    int          rstall;
    bits   = take_bits(3);
    wstall = int'(bits) + 2;
    bits   = take_bits(3);
    rstall = int'(bits) + 2;
    start_write(20'h0abcd, 16'h6c3e, 2'b11, "backpressure");
    wait_accept(1'b0);
    // Read waits on the bus while the write response is stalled
    start_read(20'h0abcd, "backpressure");
    take_resp(1'b0, wstall);
    wait_accept(1'b1);
    // A write waits on the bus while the read response is stalled
    start_write(20'h0abce, 16'h93c1, 2'b11, "backpressure late");
    take_resp(1'b1, rstall);
    wait_accept(1'b0);
    take_resp(1'b0, 0);
  endtask

  task automatic priority_test();
    send_write(20'h0c0de, 16'h1234, 2'b11, 0, "priority old");
    start_write(20'h0c0de, 16'h9e37, 2'b11, "priority");
    start_read(20'h0c0de, "priority");
    wait_accept(1'b0);
    take_resp(1'b0, 0);
    wait_accept(1'b1);
    take_resp(1'b1, 0);
  endtask

  task automatic random_test();
    logic [31:0]                bits;
    logic [sram_addr_width-1:0] addr;
    logic [sram_strb_width-1:0] strb;
    int                         stall;
    for (int i = 0; i < random_txns; i++) begin
      bits  = take_bits(4);
      addr  = {window_base[sram_addr_width-1:4], bits[3:0]};
      bits  = take_bits(3);
      stall = int'(bits);
      bits  = take_bits(1);
      if (bits[0]) begin
        bits = take_bits(3);
        strb = bits[2] ? '1 : bits[sram_strb_width-1:0];
        bits = take_bits(16);
        send_write(addr, bits[sram_data_width-1:0], strb, stall, "random write");
      end else begin
        send_read(addr, stall, "random read");
      end
    end
  endtask

  initial begin
    lfsr_state  = 32'h9c80;
    axi_resetn  = 1'b0;
    axi_awaddr  = '0;
    axi_awvalid = 1'b0;
    axi_wdata   = '0;
    axi_wstrb   = '0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_araddr  = '0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    repeat (reset_cycles) begin
      @(negedge axi_clk);
      check_idle_outputs("in reset");
    end
    @(posedge axi_clk);
    #5;
    axi_resetn = 1'b1;
    repeat (2) begin
      @(negedge axi_clk);
      check_idle_outputs("after reset");
    end
    @(posedge axi_clk);
    #5;
    readback_test();
    strobe_test();
    backpressure_test();
    priority_test();
    random_test();
    if (exp_bresp.size() != 0 || exp_rdata.size() != 0) begin
      $display("Some responses never arrived by the end of the tests");
      $display("STATUS: FAIL");
      $fatal(1, "missing responses");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: compile.f
source/sram_pkg.sv
source/sram_controller.sv
source/axi_sram_slave.sv
source/sram_subsystem_top.sv
bench/async_sram_model.sv
bench/tb_sram_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SRAM subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timescale 1ns/1ps -f compile.f \
  --top-module tb_sram_subsystem -o tb_sram_subsystem

./obj_dir/tb_sram_subsystem 2>&1 | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
